//--- armPkg.sv
package armPkg;

    localparam int WordWidth = 32;
    localparam int DataWords = 64;
    localparam logic [3:0] PcReg = 4'd15;

    localparam logic [2:0] AluAdd = 3'b000;
    localparam logic [2:0] AluSub = 3'b001;
    localparam logic [2:0] AluAnd = 3'b010;
    localparam logic [2:0] AluOrr = 3'b011;
    localparam logic [2:0] AluEor = 3'b100;

    localparam logic [1:0] ImmDp8 = 2'b00;
    localparam logic [1:0] ImmMem12 = 2'b01;
    localparam logic [1:0] ImmBr24 = 2'b10;

    localparam logic [1:0] OpDp = 2'b00;
    localparam logic [1:0] OpMem = 2'b01;
    localparam logic [1:0] OpBr = 2'b10;

    localparam logic [3:0] CondAl = 4'hE;

    typedef logic [WordWidth-1:0] word_t;
    typedef logic [3:0] regAddr_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [1:0] regSrc;  // [1] rd as B source, [0] R15 as A source
        logic [1:0] immSrc;
        logic aluSrc;
        logic memToReg;
        logic regW;
        logic memW;
        logic branch;
        logic [2:0] aluCtrl;
        logic [1:0] flagW;   // [1] NZ, [0] CV
    } ctrl_t;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] op;
        logic [5:0] funct;
        regAddr_t rn;
        regAddr_t rd;
        logic [11:0] src12;
    } dpFields_t;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] op;
        logic [1:0] funct;   // Bit 0 is the link bit
        logic [23:0] imm24;
    } brFields_t;

    typedef union packed {
        dpFields_t dp;
        brFields_t br;
    } instr_u;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu import armPkg::*; (
    input word_t a,
    input word_t b,
    input logic [2:0] aluCtrl,
    output word_t result,
    output flags_t flags
);

    logic isSub;
    logic isArith;
    logic overflow;
    logic [WordWidth:0] sum;

    assign isSub = (aluCtrl == AluSub);
    assign isArith = (aluCtrl == AluAdd) || isSub;

    // Subtract as a + ~b + 1
    assign sum = {1'b0, a} + {1'b0, isSub ? ~b : b} + {{WordWidth{1'b0}}, isSub};

    always_comb begin
        case (aluCtrl)
            AluAnd: result = a & b;
            AluOrr: result = a | b;
            AluEor: result = a ^ b;
            default: result = sum[WordWidth-1:0];
        endcase
    end

    assign overflow = ~(a[WordWidth-1] ^ b[WordWidth-1] ^ isSub)
                      & (a[WordWidth-1] ^ sum[WordWidth-1]);

    assign flags = {result[WordWidth-1], result == '0, isArith & sum[WordWidth],
                    isArith & overflow};

endmodule

//--- condUnit.sv
`timescale 1ns/1ps

module condUnit import armPkg::*; (
    input logic [3:0] cond,
    input flags_t flags,
    output logic condEx
);

    logic ge;

    assign ge = (flags.n == flags.v);

    always_comb begin
        case (cond)
            4'h0: condEx = flags.z;                // EQ
            4'h1: condEx = ~flags.z;               // NE
            4'h2: condEx = flags.c;                // CS
            4'h3: condEx = ~flags.c;               // CC
            4'h4: condEx = flags.n;                // MI
            4'h5: condEx = ~flags.n;               // PL
            4'h6: condEx = flags.v;                // VS
            4'h7: condEx = ~flags.v;               // VC
            4'h8: condEx = flags.c & ~flags.z;     // HI
            4'h9: condEx = ~flags.c | flags.z;     // LS
            4'hA: condEx = ge;
            4'hB: condEx = ~ge;                    // LT
            4'hC: condEx = ~flags.z & ge;          // GT
            4'hD: condEx = flags.z | ~ge;          // LE
            CondAl: condEx = 1'b1;
            default: condEx = 1'b0;                // Never executes
        endcase
    end

endmodule

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import armPkg::*; (
    input instr_u instr,
    output ctrl_t ctrl
);

    logic [5:0] funct;

    assign funct = instr.dp.funct;

    always_comb begin
        ctrl = '0;
        ctrl.aluCtrl = AluAdd;
        case (instr.dp.op)
            OpDp: begin
                ctrl.immSrc = ImmDp8;
                ctrl.aluSrc = funct[5];         // I bit
                ctrl.regW = 1'b1;
                ctrl.flagW = {2{funct[0]}};     // S bit
                case (funct[4:1])
                    4'b0100: ctrl.aluCtrl = AluAdd;
                    4'b0010: ctrl.aluCtrl = AluSub;
                    4'b0000: ctrl.aluCtrl = AluAnd;
                    4'b1100: ctrl.aluCtrl = AluOrr;
                    4'b0001: ctrl.aluCtrl = AluEor;
                    default: ctrl.aluCtrl = AluAdd;
                endcase
            end
            OpMem: begin
                // funct[0] is the L bit
                ctrl.regSrc = {~funct[0], 1'b0};
                ctrl.immSrc = ImmMem12;
                ctrl.aluSrc = 1'b1;
                ctrl.memToReg = funct[0];
                ctrl.regW = funct[0];
                ctrl.memW = ~funct[0];
            end
            OpBr: begin
                ctrl.regSrc = 2'b01;            // Base is PC+8
                ctrl.immSrc = ImmBr24;
                ctrl.aluSrc = 1'b1;
                ctrl.branch = 1'b1;
            end
            default: begin
                ctrl.aluCtrl = AluAdd;
            end
        endcase
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile import armPkg::*; (
    input logic clk,
    input logic writeEn,
    input regAddr_t readAddrA,
    input regAddr_t readAddrB,
    input regAddr_t writeAddr,
    input word_t writeValue,
    input word_t pcPlus8,
    output word_t readA,
    output word_t readB
);

    word_t regs [0:PcReg-1];  // R0 to R14

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[writeAddr] <= writeValue;
        end
    end

    assign readA = (readAddrA == PcReg) ? pcPlus8 : regs[readAddrA];
    assign readB = (readAddrB == PcReg) ? pcPlus8 : regs[readAddrB];

endmodule

//--- dataMem.sv
`timescale 1ns/1ps

module dataMem import armPkg::*; (
    input logic clk,
    input logic writeEn,
    input word_t addr,
    input word_t writeValue,
    output word_t readValue
);

    localparam int IndexBits = $clog2(DataWords);

    word_t ram [0:DataWords-1];
    logic [IndexBits-1:0] index;

    assign index = addr[IndexBits+1:2];  // Word address

    always_ff @(posedge clk) begin
        if (writeEn) begin
            ram[index] <= writeValue;
        end
    end

    // Captured mid-cycle so LDR writes back at the closing edge
    always_ff @(negedge clk) begin
        readValue <= ram[index];
    end

endmodule

//--- armCore.sv
`timescale 1ns/1ps

module armCore import armPkg::*; (
    input logic clk,
    input logic reset,
    input word_t instr,
    output word_t pc,
    output logic memWrite,
    output word_t dataAdr,
    output word_t writeData,
    input word_t readData
);

    instr_u ir;
    ctrl_t ctrl;
    flags_t flags;
    flags_t aluFlags;
    logic condEx;
    logic r15Write;
    logic regWrite;
    logic pcWrite;
    logic [1:0] flagWrite;
    regAddr_t addrA;
    regAddr_t addrB;
    word_t pcPlus4;
    word_t pcPlus8;
    word_t extImm;
    word_t srcA;
    word_t srcB;
    word_t aluResult;
    word_t result;

    assign ir = instr;

    instrDecoder u_instrDecoder (
        .instr(ir),
        .ctrl(ctrl)
    );

    condUnit u_condUnit (
        .cond(ir.dp.cond),
        .flags(flags),
        .condEx(condEx)
    );

    // A register write to R15 redirects the PC instead
    assign r15Write = ctrl.regW && (ir.dp.rd == PcReg);
    assign regWrite = ctrl.regW & condEx & ~r15Write;
    assign pcWrite = (ctrl.branch | r15Write) & condEx;
    assign memWrite = ctrl.memW & condEx;
    assign flagWrite = ctrl.flagW & {2{condEx}};

    assign pcPlus4 = pc + 32'd4;
    assign pcPlus8 = pc + 32'd8;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcWrite ? result : pcPlus4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else begin
            if (flagWrite[1]) begin
                {flags.n, flags.z} <= {aluFlags.n, aluFlags.z};
            end
            if (flagWrite[0]) begin
                {flags.c, flags.v} <= {aluFlags.c, aluFlags.v};
            end
        end
    end

    always_comb begin
        case (ctrl.immSrc)
            ImmDp8: extImm = {24'b0, ir.dp.src12[7:0]};
            ImmMem12: extImm = {20'b0, ir.dp.src12};
            ImmBr24: extImm = {{6{ir.br.imm24[23]}}, ir.br.imm24, 2'b00};  // Word offset
            default: extImm = '0;
        endcase
    end

    assign addrA = ctrl.regSrc[0] ? PcReg : ir.dp.rn;
    assign addrB = ctrl.regSrc[1] ? ir.dp.rd : ir.dp.src12[3:0];  // STR data comes from rd

    regFile u_regFile (
        .clk(clk),
        .writeEn(regWrite),
        .readAddrA(addrA),
        .readAddrB(addrB),
        .writeAddr(ir.dp.rd),
        .writeValue(result),
        .pcPlus8(pcPlus8),
        .readA(srcA),
        .readB(writeData)
    );

    assign srcB = ctrl.aluSrc ? extImm : writeData;

    alu u_alu (
        .a(srcA),
        .b(srcB),
        .aluCtrl(ctrl.aluCtrl),
        .result(aluResult),
        .flags(aluFlags)
    );

    assign dataAdr = aluResult;
    assign result = ctrl.memToReg ? readData : aluResult;

endmodule

//--- armCpu.sv
`timescale 1ns/1ps

module armCpu import armPkg::*; (
    input logic clk,
    input logic reset,
    input word_t instr,
    output word_t pc,
    output logic memWrite,
    output word_t dataAdr,
    output word_t writeData
);

    word_t readData;

    armCore u_armCore (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pc(pc),
        .memWrite(memWrite),
        .dataAdr(dataAdr),
        .writeData(writeData),
        .readData(readData)
    );

    dataMem u_dataMem (
        .clk(clk),
        .writeEn(memWrite),
        .addr(dataAdr),
        .writeValue(writeData),
        .readValue(readData)
    );

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- armTb.sv
`timescale 1ns/1ps

module armTb import armPkg::*; ();

    localparam logic [5:0] RecBase = 6'd24;  // Records follow the 24 program words
    localparam word_t EndMark = 32'hFFFFFFFF;
    localparam word_t LastPc = 32'd92;       // Branch to itself

    logic clk;
    logic reset;
    logic memWrite;
    logic done;
    word_t instr;
    word_t pc;
    word_t dataAdr;
    word_t writeData;
    word_t expPc;
    word_t vectors [0:63];
    logic [5:0] recIdx;
    int recordCount;

    tbClock u_tbClock (
        .clk(clk),
        .reset(reset)
    );

    armCpu u_armCpu (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pc(pc),
        .memWrite(memWrite),
        .dataAdr(dataAdr),
        .writeData(writeData)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkPc(input word_t expected);
        if (pc !== expected) begin
            abortRun($sformatf("FAILED at %0d ns: pc %h, expected %h", $time, pc, expected));
        end
    endtask

    task automatic checkStore(input word_t addr, input word_t data);
        if (dataAdr !== addr) begin
            abortRun($sformatf("FAILED at %0d ns: dataAdr %h, expected %h",
                               $time, dataAdr, addr));
        end
        if (writeData !== data) begin
            abortRun($sformatf("FAILED at %0d ns: writeData %h, expected %h",
                               $time, writeData, data));
        end
    endtask

    // Only B under AL is taken in this program
    function automatic word_t nextPc(input word_t at);
        instr_u fetched;
        fetched = vectors[at[7:2]];
        if (fetched.br.op == OpBr && fetched.br.cond == CondAl) begin
            return at + 32'd8 + 32'd4 * 32'($signed(fetched.br.imm24));
        end
        return at + 32'd4;
    endfunction

    initial begin
        $readmemh("armVectors.mem", vectors);
        recordCount = 0;
        recIdx = RecBase;
        while (vectors[recIdx] !== EndMark && recIdx < 6'd62) begin
            recordCount++;
            recIdx = recIdx + 6'd2;
        end
        recIdx = RecBase;
        expPc = '0;
        done = 1'b0;
        instr <= vectors[6'd0];
        while (!done) begin
            @(negedge clk);  // Outputs settled mid-cycle
            if (!reset) begin
                checkPc(expPc);
                if (memWrite && vectors[recIdx] === EndMark) begin
                    abortRun("A store was seen after the last expected record");
                end else if (memWrite) begin
                    checkStore(vectors[recIdx], vectors[recIdx + 6'd1]);
                    recIdx = recIdx + 6'd2;
                end
                done = (vectors[recIdx] === EndMark) && (expPc == LastPc);
            end
            @(posedge clk);
            if (!reset) begin
                expPc = nextPc(expPc);
            end
            instr <= vectors[expPc[7:2]];
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #1;
        repeat ((24 + 4 * recordCount) * 8) @(posedge clk);
        abortRun("Timeout because the program did not produce all expected stores");
    end

endmodule

//--- armVectors.mem
// Words 0 to 23 hold the program, then store address and data pairs up to FFFFFFFF
E28F0000 // ADD   R0, R15, #0
E2801052 // ADD   R1, R0, #0x52
E2802034 // ADD   R2, R0, #0x34
E0813002 // ADD   R3, R1, R2
E5803038 // STR   R3, [R0, #0x38]
E0424001 // SUB   R4, R2, R1
E580403C // STR   R4, [R0, #0x3C]
EA000000 // B     0x24
EA000001 // B     0x2C
E201503C // AND   R5, R1, #0x3C
EAFFFFFC // B     0x20
E221603C // EOR   R6, R1, #0x3C
E1817002 // ORR   R7, R1, R2
E251805A // SUBS  R8, R1, #0x5A
05805040 // STREQ R5, [R0, #0x40]
15806060 // STRNE R6, [R0, #0x60]
12528001 // SUBNES R8, R2, #1
05806044 // STREQ R6, [R0, #0x44]
E5807048 // STR   R7, [R0, #0x48]
E5909038 // LDR   R9, [R0, #0x38]
FAFFFFFB // BNV   0x44
E580904C // STR   R9, [R0, #0x4C]
E5800050 // STR   R0, [R0, #0x50]
EAFFFFFE // B     0x5C
00000040 00000096
00000044 FFFFFFE2
00000048 00000018
0000004C 00000066
00000050 0000007E
00000054 00000096
00000058 00000008
FFFFFFFF

//--- armCpu.f
armPkg.sv
alu.sv
condUnit.sv
instrDecoder.sv
regFile.sv
dataMem.sv
armCore.sv
armCpu.sv
tbClock.sv
armTb.sv

//--- Makefile
SIM = obj_dir/VarmTb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

$(SIM): $(wildcard *.sv) armCpu.f
	verilator --binary --timing --top-module armTb -f armCpu.f

clean:
	rm -rf obj_dir

.PHONY: run clean
